// ==== cpu_isa_pkg.sv ====
`default_nettype none

package cpu_isa_pkg;

  // opcode split as grp(7:6) y(5:3) z(2:0)
  typedef struct packed {
    logic [1:0] grp;
    logic [2:0] y;
    logic [2:0] z;
  } opcode_t;

  localparam logic [7:0] OPC_HALT = 8'h76;  // runs as a nop here

  typedef enum logic [2:0] {
    R_B      = 3'd0,
    R_C      = 3'd1,
    R_D      = 3'd2,
    R_E      = 3'd3,
    R_H      = 3'd4,
    R_L      = 3'd5,
    R_HL_MEM = 3'd6,
    R_A      = 3'd7
  } reg8_e;

  typedef enum logic [1:0] {
    P_BC = 2'd0,
    P_DE = 2'd1,
    P_HL = 2'd2
  } reg16_e;

  typedef enum logic [2:0] {
    OP_PASS,
    OP_ADD,
    OP_ADC,
    OP_SUB,
    OP_INC,
    OP_DEC,
    OP_INC16,
    OP_DEC16
  } alu_op_e;

  typedef enum logic [2:0] {
    C_NOP,
    C_LD_R,
    C_ALU8,
    C_LD_RR_IMM,
    C_INCDEC16
  } instr_class_e;

  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_RD,
    MEM_WR
  } mem_kind_e;

  typedef struct packed {
    instr_class_e cls;
    reg8_e        dst;
    reg8_e        src;
    reg16_e       pair;
    alu_op_e      alu_op;
    logic [1:0]   imm_bytes;
    mem_kind_e    mem;
    logic         extra;  // one idle execute M-cycle
  } decoded_t;

endpackage

`default_nettype wire

// ==== cpu_core_pkg.sv ====
`default_nettype none

package cpu_core_pkg;

  typedef logic [15:0] addr_t;
  typedef logic [7:0]  data_t;

  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
  } mem_req_t;

  // write-back record, applied by reg_file on the next edge
  typedef struct packed {
    logic                we8;
    cpu_isa_pkg::reg8_e  sel8;
    data_t               data8;
    logic                we16;
    cpu_isa_pkg::reg16_e sel16;
    logic [15:0]         data16;
    logic                carry_we;
    logic                carry;
  } reg_wr_t;

  typedef struct packed {
    logic [15:0] value;
    logic        carry;
  } alu_res_t;

  localparam addr_t       RESET_PC_DEFAULT = 16'h0100;
  localparam int unsigned T_STATES_DEFAULT = 4;  // clocks per M-cycle

endpackage

`default_nettype wire

// ==== instr_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_decode (
  input  wire cpu_core_pkg::data_t   i_opcode,
  output cpu_isa_pkg::decoded_t      o_dec
);

  import cpu_isa_pkg::*;

  opcode_t op;

  assign op = i_opcode;

  always_comb begin
    o_dec      = '0;
    o_dec.pair = P_HL;  // memory forms address through HL
    case (op.grp)
      2'b01: begin
        if (i_opcode != OPC_HALT) begin
          o_dec.cls = C_LD_R;
          o_dec.dst = reg8_e'(op.y);
          o_dec.src = reg8_e'(op.z);
          if (op.z == R_HL_MEM) begin
            o_dec.mem = MEM_RD;
          end else if (op.y == R_HL_MEM) begin
            o_dec.mem = MEM_WR;
          end
        end
      end
      2'b10: begin
        if (op.y <= 3'd2 && op.z != R_HL_MEM) begin  // add, adc, sub only
          o_dec.cls = C_ALU8;
          o_dec.dst = R_A;
          o_dec.src = reg8_e'(op.z);
          case (op.y)
            3'd0:    o_dec.alu_op = OP_ADD;
            3'd1:    o_dec.alu_op = OP_ADC;
            default: o_dec.alu_op = OP_SUB;
          endcase
        end
      end
      2'b00: begin
        case (op.z)
          3'd1: begin
            if (!op.y[0] && op.y[2:1] != 2'd3) begin  // ld rr,d16 without sp
              o_dec.cls       = C_LD_RR_IMM;
              o_dec.pair      = reg16_e'(op.y[2:1]);
              o_dec.imm_bytes = 2'd2;
            end
          end
          3'd3: begin
            if (op.y[2:1] != 2'd3) begin
              o_dec.cls    = C_INCDEC16;
              o_dec.pair   = reg16_e'(op.y[2:1]);
              o_dec.alu_op = op.y[0] ? OP_DEC16 : OP_INC16;
              o_dec.extra  = 1'b1;
            end
          end
          3'd4, 3'd5: begin
            if (op.y != R_HL_MEM) begin
              o_dec.cls    = C_ALU8;
              o_dec.dst    = reg8_e'(op.y);
              o_dec.src    = reg8_e'(op.y);
              o_dec.alu_op = op.z[0] ? OP_DEC : OP_INC;
            end
          end
          3'd6: begin
            o_dec.cls       = C_LD_R;
            o_dec.dst       = reg8_e'(op.y);
            o_dec.imm_bytes = 2'd1;
            o_dec.mem       = (op.y == R_HL_MEM) ? MEM_WR : MEM_NONE;
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  wire cpu_isa_pkg::alu_op_e i_op,
  input  wire cpu_core_pkg::data_t  i_a,
  input  wire cpu_core_pkg::data_t  i_b,
  input  wire logic [15:0]          i_pair,
  input  wire logic                 i_carry,
  output cpu_core_pkg::alu_res_t    o_res
);

  import cpu_isa_pkg::*;

  logic [8:0] sum;  // bit 8 is carry or borrow

  always_comb begin
    sum         = 9'h000;
    o_res.value = {8'h00, i_b};
    o_res.carry = i_carry;
    case (i_op)
      OP_ADD: begin
        sum         = {1'b0, i_a} + {1'b0, i_b};
        o_res.value = {8'h00, sum[7:0]};
        o_res.carry = sum[8];
      end
      OP_ADC: begin
        sum         = {1'b0, i_a} + {1'b0, i_b} + {8'h00, i_carry};
        o_res.value = {8'h00, sum[7:0]};
        o_res.carry = sum[8];
      end
      OP_SUB: begin
        sum         = {1'b0, i_a} - {1'b0, i_b};
        o_res.value = {8'h00, sum[7:0]};
        o_res.carry = sum[8];
      end
      OP_INC: begin
        o_res.value = {8'h00, i_a + 8'd1};  // flag left alone
      end
      OP_DEC: begin
        o_res.value = {8'h00, i_a - 8'd1};
      end
      OP_INC16: begin
        o_res.value = i_pair + 16'd1;
      end
      OP_DEC16: begin
        o_res.value = i_pair - 16'd1;
      end
      default: ;  // pass
    endcase
  end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  wire logic                  i_clk,
  input  wire logic                  i_rst,
  input  wire cpu_isa_pkg::reg8_e    i_sel_a,
  input  wire cpu_isa_pkg::reg8_e    i_sel_b,
  input  wire cpu_isa_pkg::reg16_e   i_sel_pair,
  input  wire cpu_core_pkg::reg_wr_t i_wr,
  output cpu_core_pkg::data_t        o_rd_a,
  output cpu_core_pkg::data_t        o_rd_b,
  output logic [15:0]                o_pair,
  output logic                       o_carry
);

  import cpu_isa_pkg::*;

  logic [7:0] regs [8];  // indexed by register code, slot 6 is never written
  logic       carry_q;

  always_ff @(posedge i_clk, posedge i_rst) begin
    if (i_rst) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= 8'h00;
      end
      carry_q <= 1'b0;
    end else begin
      if (i_wr.we16) begin
        regs[{i_wr.sel16, 1'b0}] <= i_wr.data16[15:8];  // b, d, h
        regs[{i_wr.sel16, 1'b1}] <= i_wr.data16[7:0];   // c, e, l
      end
      if (i_wr.we8 && i_wr.sel8 != R_HL_MEM) begin
        regs[i_wr.sel8] <= i_wr.data8;
      end
      if (i_wr.carry_we) begin
        carry_q <= i_wr.carry;
      end
    end
  end

  assign o_rd_a  = regs[i_sel_a];
  assign o_rd_b  = regs[i_sel_b];
  assign o_pair  = {regs[{i_sel_pair, 1'b0}], regs[{i_sel_pair, 1'b1}]};
  assign o_carry = carry_q;

endmodule

`default_nettype wire

// ==== bus_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_unit (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  input  wire logic                i_req,
  input  wire logic                i_from_hl,
  input  wire logic                i_wr,
  input  wire cpu_core_pkg::data_t i_wr_data,
  input  wire cpu_core_pkg::addr_t i_pc,
  input  wire logic [15:0]         i_hl,
  output cpu_core_pkg::mem_req_t   o_mem
);

  import cpu_core_pkg::*;

  addr_t addr_q;
  logic  we_q;
  data_t wdata_q;

  always_ff @(posedge i_clk, posedge i_rst) begin
    if (i_rst) begin
      addr_q <= '0;
      we_q   <= 1'b0;
    end else begin
      we_q <= i_req && i_wr;  // single clock pulse
      if (i_req) begin
        addr_q <= i_from_hl ? i_hl : i_pc;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_req) wdata_q <= i_wr_data;
  end

  assign o_mem = '{addr: addr_q, we: we_q, wdata: wdata_q};

  a_wr_from_hl: assert property (@(posedge i_clk) disable iff (i_rst)
    i_req && i_wr |-> i_from_hl);

endmodule

`default_nettype wire

// ==== core_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_ctrl #(
  parameter int unsigned         T_STATES = cpu_core_pkg::T_STATES_DEFAULT,
  parameter cpu_core_pkg::addr_t RESET_PC = cpu_core_pkg::RESET_PC_DEFAULT
) (
  input  wire logic                  i_clk,
  input  wire logic                  i_rst,
  input  wire cpu_core_pkg::data_t    i_mem_rd_data,
  input  wire cpu_core_pkg::alu_res_t i_alu,
  input  wire cpu_core_pkg::data_t    i_rd_a,
  input  wire cpu_core_pkg::data_t    i_rd_b,
  input  wire logic [15:0]           i_pair,
  input  wire logic                  i_carry,
  output cpu_isa_pkg::reg8_e         o_sel_a,
  output cpu_isa_pkg::reg8_e         o_sel_b,
  output cpu_isa_pkg::reg16_e        o_sel_pair,
  output cpu_isa_pkg::alu_op_e       o_alu_op,
  output cpu_core_pkg::data_t        o_alu_a,
  output cpu_core_pkg::data_t        o_alu_b,
  output cpu_core_pkg::reg_wr_t      o_reg_wr,
  output logic                       o_bus_req,
  output logic                       o_bus_from_hl,
  output logic                       o_bus_wr,
  output cpu_core_pkg::data_t        o_bus_wr_data,
  output cpu_core_pkg::addr_t        o_pc
);

  import cpu_isa_pkg::*;
  import cpu_core_pkg::*;

  localparam int unsigned TW = $clog2(T_STATES);

  typedef enum logic [2:0] {S_FETCH, S_IMM_LO, S_IMM_HI, S_MEM, S_EXEC} state_e;

  state_e   state, state_nx;
  logic [TW-1:0] t_cnt;
  logic     t_last;
  logic     final_clk;
  addr_t    pc;
  data_t    ir;
  data_t    imm_lo;
  data_t    opcode;
  decoded_t dec;

  // opcode is only valid on the data bus during the fetch itself
  assign opcode = (state == S_FETCH) ? i_mem_rd_data : ir;

  instr_decode u_decode (
    .i_opcode (opcode),
    .o_dec    (dec)
  );

  assign t_last    = (t_cnt == TW'(T_STATES - 1));
  assign final_clk = t_last && (state_nx == S_FETCH);

  always_comb begin
    state_nx = state;
    if (t_last) begin
      case (state)
        S_FETCH: begin
          if (dec.imm_bytes != 2'd0)   state_nx = S_IMM_LO;
          else if (dec.mem != MEM_NONE) state_nx = S_MEM;
          else if (dec.extra)          state_nx = S_EXEC;
          else                         state_nx = S_FETCH;
        end
        S_IMM_LO: begin
          if (dec.imm_bytes == 2'd2)   state_nx = S_IMM_HI;
          else if (dec.mem != MEM_NONE) state_nx = S_MEM;
          else                         state_nx = S_FETCH;
        end
        default: state_nx = S_FETCH;
      endcase
    end
  end

  always_ff @(posedge i_clk, posedge i_rst) begin
    if (i_rst) begin
      state <= S_FETCH;
      t_cnt <= '0;
      pc    <= RESET_PC;
    end else begin
      state <= state_nx;
      t_cnt <= t_last ? '0 : t_cnt + 1'b1;
      if (o_bus_req && !o_bus_from_hl) begin
        pc <= pc + 16'd1;  // opcode and immediate fetches
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (t_last && state == S_FETCH) ir <= i_mem_rd_data;
    if (t_last && state == S_IMM_LO) imm_lo <= i_mem_rd_data;
  end

  // address goes out on the first clock of every M-cycle except exec
  assign o_bus_req     = (t_cnt == '0) && (state != S_EXEC);
  assign o_bus_from_hl = (state == S_MEM);
  assign o_bus_wr      = (state == S_MEM) && (dec.mem == MEM_WR);
  assign o_bus_wr_data = (dec.imm_bytes != 2'd0) ? imm_lo : i_rd_b;
  assign o_pc          = pc;

  assign o_sel_a    = dec.dst;
  assign o_sel_b    = dec.src;
  assign o_sel_pair = dec.pair;
  assign o_alu_op   = dec.alu_op;
  assign o_alu_a    = i_rd_a;
  assign o_alu_b    = (state == S_IMM_LO || state == S_MEM) ? i_mem_rd_data : i_rd_b;

  always_comb begin
    o_reg_wr        = '0;
    o_reg_wr.sel8   = dec.dst;
    o_reg_wr.data8  = i_alu.value[7:0];
    o_reg_wr.sel16  = dec.pair;
    o_reg_wr.data16 = (dec.cls == C_LD_RR_IMM) ? {i_mem_rd_data, imm_lo} : i_alu.value;
    o_reg_wr.carry  = i_alu.carry;
    if (final_clk) begin
      o_reg_wr.we8      = (dec.cls == C_LD_R || dec.cls == C_ALU8) && (dec.dst != R_HL_MEM);
      o_reg_wr.we16     = (dec.cls == C_LD_RR_IMM) || (dec.cls == C_INCDEC16);
      o_reg_wr.carry_we = (dec.cls == C_ALU8);
    end
  end

  a_t_states: assert property (@(posedge i_clk) T_STATES >= 2);

  a_mem_kind: assert property (@(posedge i_clk) disable iff (i_rst)
    (state != S_MEM) ##1 (state == S_MEM) |-> dec.mem != MEM_NONE);

endmodule

`default_nettype wire

// ==== gb_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module gb_core #(
  parameter int unsigned         T_STATES = cpu_core_pkg::T_STATES_DEFAULT,
  parameter cpu_core_pkg::addr_t RESET_PC = cpu_core_pkg::RESET_PC_DEFAULT
) (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  input  wire cpu_core_pkg::data_t i_mem_rd_data,
  output cpu_core_pkg::mem_req_t   o_mem
);

  import cpu_isa_pkg::*;
  import cpu_core_pkg::*;

  reg8_e       sel_a;
  reg8_e       sel_b;
  reg16_e      sel_pair;
  alu_op_e     alu_op;
  data_t       alu_a;
  data_t       alu_b;
  alu_res_t    alu_res;
  reg_wr_t     reg_wr;
  data_t       rd_a;
  data_t       rd_b;
  logic [15:0] pair;
  logic        carry;
  logic        bus_req;
  logic        bus_from_hl;
  logic        bus_wr;
  data_t       bus_wr_data;
  addr_t       pc;

  core_ctrl #(
    .T_STATES (T_STATES),
    .RESET_PC (RESET_PC)
  ) u_ctrl (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_mem_rd_data (i_mem_rd_data),
    .i_alu         (alu_res),
    .i_rd_a        (rd_a),
    .i_rd_b        (rd_b),
    .i_pair        (pair),
    .i_carry       (carry),
    .o_sel_a       (sel_a),
    .o_sel_b       (sel_b),
    .o_sel_pair    (sel_pair),
    .o_alu_op      (alu_op),
    .o_alu_a       (alu_a),
    .o_alu_b       (alu_b),
    .o_reg_wr      (reg_wr),
    .o_bus_req     (bus_req),
    .o_bus_from_hl (bus_from_hl),
    .o_bus_wr      (bus_wr),
    .o_bus_wr_data (bus_wr_data),
    .o_pc          (pc)
  );

  reg_file u_regs (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_sel_a    (sel_a),
    .i_sel_b    (sel_b),
    .i_sel_pair (sel_pair),
    .i_wr       (reg_wr),
    .o_rd_a     (rd_a),
    .o_rd_b     (rd_b),
    .o_pair     (pair),
    .o_carry    (carry)
  );

  alu u_alu (
    .i_op    (alu_op),
    .i_a     (alu_a),
    .i_b     (alu_b),
    .i_pair  (pair),
    .i_carry (carry),
    .o_res   (alu_res)
  );

  // pair port reads HL whenever the decoded op touches memory
  bus_unit u_bus (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_req     (bus_req),
    .i_from_hl (bus_from_hl),
    .i_wr      (bus_wr),
    .i_wr_data (bus_wr_data),
    .i_pc      (pc),
    .i_hl      (pair),
    .o_mem     (o_mem)
  );

endmodule

`default_nettype wire

// ==== tb_cases.svh ====
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

typedef enum logic [2:0] {X_FIXED, X_COPY, X_ADD, X_SUB, X_ADCA, X_ADCS} rule_e;

// prog is right aligned, the first byte sits at index len-1
// pos0..pos2 are byte offsets that get a random operand, 0 means unused
typedef struct packed {
  logic [15:0][7:0] prog;
  logic [4:0]       len;
  logic [5:0]       mcyc;  // M-cycles of the whole fragment
  rule_e            rule;
  logic [3:0]       pos0;
  logic [3:0]       pos1;
  logic [3:0]       pos2;
  logic [1:0]       nwr;
  addr_t            addr0;
  data_t            data0;
  addr_t            addr1;
  data_t            data1;
} case_t;

localparam int NUM_CASES = 13;

localparam case_t CASES [NUM_CASES] = '{
  '{128'h06_00_48_21_00_C0_71, 5'd7, 6'd8, X_COPY, 4'd1, 4'd0, 4'd0, 2'd1,
    16'hC000, 8'h00, 16'h0000, 8'h00},
  '{128'h16_00_5A_21_10_C0_73, 5'd7, 6'd8, X_COPY, 4'd1, 4'd0, 4'd0, 2'd1,
    16'hC010, 8'h00, 16'h0000, 8'h00},
  '{128'h3E_00_47_21_20_C0_70, 5'd7, 6'd8, X_COPY, 4'd1, 4'd0, 4'd0, 2'd1,
    16'hC020, 8'h00, 16'h0000, 8'h00},
  '{128'h21_34_C1_74_75, 5'd5, 6'd7, X_FIXED, 4'd0, 4'd0, 4'd0, 2'd2,
    16'hC134, 8'hC1, 16'hC134, 8'h34},
  '{128'h01_FF_FF_03_60_69_36_AA, 5'd8, 6'd10, X_FIXED, 4'd0, 4'd0, 4'd0, 2'd1,
    16'h0000, 8'hAA, 16'h0000, 8'h00},
  '{128'h11_00_00_1B_62_6B_36_55, 5'd8, 6'd10, X_FIXED, 4'd0, 4'd0, 4'd0, 2'd1,
    16'hFFFF, 8'h55, 16'h0000, 8'h00},
  '{128'h21_FE_FF_23_36_5A_2B_36_A5, 5'd9, 6'd13, X_FIXED, 4'd0, 4'd0, 4'd0, 2'd2,
    16'hFFFF, 8'h5A, 16'hFFFE, 8'hA5},
  '{128'h3E_00_06_00_80_21_00_C2_77, 5'd9, 6'd10, X_ADD, 4'd1, 4'd3, 4'd0, 2'd1,
    16'hC200, 8'h00, 16'h0000, 8'h00},
  '{128'h3E_00_0E_00_91_21_10_C2_77, 5'd9, 6'd10, X_SUB, 4'd1, 4'd3, 4'd0, 2'd1,
    16'hC210, 8'h00, 16'h0000, 8'h00},
  '{128'h3E_00_06_00_80_16_00_8A_21_20_C2_77, 5'd12, 6'd13, X_ADCA, 4'd1, 4'd3, 4'd6,
    2'd1, 16'hC220, 8'h00, 16'h0000, 8'h00},
  '{128'h3E_00_06_00_90_16_00_8A_21_30_C2_77, 5'd12, 6'd13, X_ADCS, 4'd1, 4'd3, 4'd6,
    2'd1, 16'hC230, 8'h00, 16'h0000, 8'h00},
  '{128'h21_00_C3_36_00_4E_21_01_C3_71, 5'd10, 6'd13, X_COPY, 4'd4, 4'd0, 4'd0, 2'd2,
    16'hC300, 8'h00, 16'hC301, 8'h00},
  // carry set by add must survive inc c and dec d, then adc picks it up
  '{128'h3E_FF_06_01_80_0E_FF_0C_15_89_21_00_C4_77_72, 5'd15, 6'd17, X_FIXED,
    4'd0, 4'd0, 4'd0, 2'd2, 16'hC400, 8'h01, 16'hC400, 8'hFF}
};

`endif

// ==== tb_gb_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_gb_core;

  import cpu_isa_pkg::*;
  import cpu_core_pkg::*;

  localparam int    T_STATES   = 4;
  localparam int    CLK_NS     = 20;
  localparam int    RST_CYCLES = 16;
  localparam addr_t BASE       = RESET_PC_DEFAULT;

  `include "tb_cases.svh"

  logic     i_clk;
  logic     i_rst;
  data_t    i_mem_rd_data;
  mem_req_t o_mem;

  logic [7:0] mem [65536];
  mem_req_t   wr_q [$];
  addr_t      fetch_exp;
  addr_t      last_addr;
  addr_t      win_end;  // program bytes plus nop padding
  int         err_cnt;
  int         chk_cnt;

  gb_core #(
    .T_STATES (T_STATES),
    .RESET_PC (BASE)
  ) u_dut (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_mem_rd_data (i_mem_rd_data),
    .o_mem         (o_mem)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_NS / 2) i_clk = ~i_clk;
  end

  task automatic check_write(input mem_req_t got, input mem_req_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %0t: write got addr %h data %h, expected addr %h data %h",
               $time, got.addr, got.wdata, exp.addr, exp.wdata);
    end
  endtask

  task automatic check_fetch(input addr_t got, input addr_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %0t: fetch address %h, expected %h", $time, got, exp);
    end
  endtask

  function automatic data_t expect_data(input rule_e rule, input data_t fixed,
                                        input data_t r0, input data_t r1, input data_t r2);
    logic [8:0] s;
    s = {1'b0, r0} + {1'b0, r1};
    if (rule == X_SUB || rule == X_ADCS) s = {1'b0, r0} - {1'b0, r1};  // bit 8 becomes the borrow
    case (rule)
      X_COPY:         return r0;
      X_ADD:          return s[7:0];
      X_SUB:          return s[7:0];
      X_ADCA, X_ADCS: return s[7:0] + r2 + {7'd0, s[8]};
      default:        return fixed;
    endcase
  endfunction

  // memory model, fetch tracking and write capture
  always @(negedge i_clk) begin
    if (!i_rst) begin
      if (o_mem.we) begin
        mem[o_mem.addr] = o_mem.wdata;
        wr_q.push_back(o_mem);
      end
      if (o_mem.addr != last_addr) begin
        last_addr = o_mem.addr;
        if (o_mem.addr >= BASE && o_mem.addr < win_end) begin
          check_fetch(o_mem.addr, fetch_exp);
          fetch_exp = fetch_exp + 16'd1;
        end
      end
    end
    i_mem_rd_data <= mem[o_mem.addr];
  end

  task automatic run_case(input int idx);
    case_t    c;
    data_t    r [3];
    mem_req_t exp;
    int       bi;
    c = CASES[idx];
    for (int k = 0; k < 3; k++)
      r[k] = data_t'($urandom);
    if (c.pos0 != 4'd0) c.prog[int'(c.len) - 1 - int'(c.pos0)] = r[0];
    if (c.pos1 != 4'd0) c.prog[int'(c.len) - 1 - int'(c.pos1)] = r[1];
    if (c.pos2 != 4'd0) c.prog[int'(c.len) - 1 - int'(c.pos2)] = r[2];
    @(negedge i_clk);
    i_rst = 1'b1;
    for (int k = 0; k < 20; k++) begin
      bi = int'(c.len) - 1 - k;
      if (bi >= 0) mem[BASE + k] = c.prog[bi];
      else mem[BASE + k] = 8'h00;
    end
    wr_q.delete();
    fetch_exp = BASE;
    last_addr = '0;
    win_end   = BASE + 16'(c.len) + 16'd4;
    repeat (RST_CYCLES) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    if (o_mem.we !== 1'b0) begin
      err_cnt++;
      $display("FAIL %0t: case %0d write enable is high right after reset", $time, idx);
    end
    while (wr_q.size() < int'(c.nwr)) @(posedge i_clk);
    for (int k = 0; k < int'(c.nwr); k++) begin
      exp.addr  = (k == 0) ? c.addr0 : c.addr1;
      exp.we    = 1'b1;
      exp.wdata = expect_data(c.rule, (k == 0) ? c.data0 : c.data1, r[0], r[1], r[2]);
      check_write(wr_q[k], exp);
    end
    check_fetch(fetch_exp, BASE + 16'(c.len));  // every byte fetched once
    repeat (2) @(posedge i_clk);
    if (wr_q.size() != int'(c.nwr)) begin
      err_cnt++;
      $display("FAIL %0t: case %0d saw %0d memory writes, expected %0d",
               $time, idx, wr_q.size(), c.nwr);
    end
  endtask

  initial begin
    void'($urandom(32'hb212_e6c2));
    i_rst         = 1'b1;
    i_mem_rd_data = 8'h00;
    err_cnt       = 0;
    chk_cnt       = 0;
    fetch_exp     = BASE;
    last_addr     = '0;
    win_end       = BASE;
    for (int a = 0; a < 65536; a++)
      mem[a] = 8'(a >> 8) ^ 8'(a) ^ 8'h3c;
    for (int idx = 0; idx < NUM_CASES; idx++)
      run_case(idx);
    $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    longint limit;
    limit = 0;
    for (int k = 0; k < NUM_CASES; k++)
      limit += longint'(CASES[k].mcyc) * T_STATES * CLK_NS * 2 + (RST_CYCLES + 4) * CLK_NS;
    #(limit);
    $display("timeout: run did not finish within %0d ns", limit);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
cpu_isa_pkg.sv
cpu_core_pkg.sv
instr_decode.sv
alu.sv
reg_file.sv
bus_unit.sv
core_ctrl.sv
gb_core.sv
tb_gb_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the gb_core testbench with Verilator

verilator --binary --timing --assert -f verilog.f --top-module tb_gb_core \
  -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "no result in log"; exit 1; }
echo "simulation passed"
exit 0
